/* hw/ooo_cfg_pkg.sv */
`default_nettype none

package ooo_cfg_pkg;

    // datapath and register file
    localparam int xlen       = 32;
    localparam int reg_num    = 32;
    localparam int reg_addr_w = 5;   // log2(reg_num)

    // reorder buffer, power of two so tags wrap naturally
    localparam int rob_depth = 8;
    localparam int rob_tag_w = 3;

    // station sizes
    localparam int rs_alu_depth  = 4;
    localparam int rs_mult_depth = 2;

    localparam int mult_stages = 3;  // product latency, issue to bus

    typedef logic [xlen-1:0]       data_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;
    typedef logic [rob_tag_w-1:0]  rob_tag_t;  // rename tag = rob slot

endpackage

`default_nettype wire

/* hw/ooo_isa_pkg.sv */
`default_nettype none

package ooo_isa_pkg;

    // pre-decoded operations, encoding shared with the stim file
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_sll = 4'd5,
        op_slt = 4'd6,  // signed
        op_mul = 4'd7
    } op_e;

    // which station an op goes to
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_e;

endpackage

`default_nettype wire

/* hw/dispatch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_unit (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  ooo_isa_pkg::op_e          in_op,
    input  ooo_cfg_pkg::reg_idx_t     in_rd,
    input  ooo_cfg_pkg::reg_idx_t     in_rs1,
    input  ooo_cfg_pkg::reg_idx_t     in_rs2,
    input  logic                      in_use_imm,
    input  ooo_cfg_pkg::data_t        in_imm,
    output logic                      in_ready,
    output logic                      rob_alloc,
    input  ooo_cfg_pkg::rob_tag_t     rob_alloc_tag,
    input  logic                      rob_full,
    output ooo_cfg_pkg::rob_tag_t     lookup1_tag,
    input  logic                      lookup1_ready,
    input  ooo_cfg_pkg::data_t        lookup1_value,
    output ooo_cfg_pkg::rob_tag_t     lookup2_tag,
    input  logic                      lookup2_ready,
    input  ooo_cfg_pkg::data_t        lookup2_value,
    input  logic                      rs_alu_full,
    input  logic                      rs_mult_full,
    output logic                      rs_alu_load,
    output logic                      rs_mult_load,
    output ooo_isa_pkg::op_e          rs_op,
    output ooo_cfg_pkg::rob_tag_t     rs_dst_tag,
    output logic                      src1_ready,
    output ooo_cfg_pkg::rob_tag_t     src1_tag,
    output ooo_cfg_pkg::data_t        src1_value,
    output logic                      src2_ready,
    output ooo_cfg_pkg::rob_tag_t     src2_tag,
    output ooo_cfg_pkg::data_t        src2_value,
    input  logic                      commit_valid,
    input  ooo_cfg_pkg::reg_idx_t     commit_idx,
    input  ooo_cfg_pkg::data_t        commit_data,
    input  ooo_cfg_pkg::rob_tag_t     commit_tag,
    input  logic                      cdb_valid,
    input  ooo_cfg_pkg::rob_tag_t     cdb_tag,
    input  ooo_cfg_pkg::data_t        cdb_value
);

    ooo_cfg_pkg::data_t                 regs [ooo_cfg_pkg::reg_num];
    logic [ooo_cfg_pkg::reg_num-1:0]    rename_vld;  // value lives in the rob
    ooo_cfg_pkg::rob_tag_t              rename_tag [ooo_cfg_pkg::reg_num];
    ooo_isa_pkg::fu_e                   fu_class;
    logic                               fire;

    // pick register file, rob entry or the result on the bus right now
    function automatic logic [ooo_cfg_pkg::xlen:0] resolve(
        input logic                  busy,
        input ooo_cfg_pkg::data_t    rf_val,
        input ooo_cfg_pkg::rob_tag_t tag,
        input logic                  lk_rdy,
        input ooo_cfg_pkg::data_t    lk_val
    );
        if (!busy) return {1'b1, rf_val};
        if (lk_rdy) return {1'b1, lk_val};
        if (cdb_valid && cdb_tag == tag) return {1'b1, cdb_value};  // same-cycle bypass
        return {1'b0, lk_val};  // still waiting, station snoops the tag
    endfunction

    assign fu_class = (in_op == ooo_isa_pkg::op_mul) ? ooo_isa_pkg::fu_mult
                                                     : ooo_isa_pkg::fu_alu;
    assign in_ready = !rob_full &&
                      ((fu_class == ooo_isa_pkg::fu_mult) ? !rs_mult_full : !rs_alu_full);
    assign fire         = in_valid && in_ready;
    assign rob_alloc    = fire;
    assign rs_alu_load  = fire && fu_class == ooo_isa_pkg::fu_alu;
    assign rs_mult_load = fire && fu_class == ooo_isa_pkg::fu_mult;
    assign rs_op        = in_op;
    assign rs_dst_tag   = rob_alloc_tag;  // new name for rd

    assign src1_tag    = rename_tag[in_rs1];
    assign src2_tag    = rename_tag[in_rs2];
    assign lookup1_tag = src1_tag;
    assign lookup2_tag = src2_tag;

    always_comb begin
        {src1_ready, src1_value} = resolve(rename_vld[in_rs1], regs[in_rs1], src1_tag,
                                           lookup1_ready, lookup1_value);
        {src2_ready, src2_value} = resolve(rename_vld[in_rs2], regs[in_rs2], src2_tag,
                                           lookup2_ready, lookup2_value);
        if (in_use_imm) begin
            src2_ready = 1'b1;
            src2_value = in_imm;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rename_vld <= '0;
            for (int i = 0; i < ooo_cfg_pkg::reg_num; i++) begin
                regs[i]       <= '0;
                rename_tag[i] <= '0;
            end
        end else begin
            if (commit_valid && commit_idx != '0) begin  // r0 stays zero
                regs[commit_idx] <= commit_data;
                if (rename_vld[commit_idx] && rename_tag[commit_idx] == commit_tag)
                    rename_vld[commit_idx] <= 1'b0;  // no younger writer
            end
            // rename after commit so a new writer wins
            if (fire && in_rd != '0) begin
                rename_vld[in_rd] <= 1'b1;
                rename_tag[in_rd] <= rob_alloc_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int depth = 4
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      load,
    input  ooo_isa_pkg::op_e          op,
    input  logic                      src1_ready,
    input  ooo_cfg_pkg::rob_tag_t     src1_tag,
    input  ooo_cfg_pkg::data_t        src1_value,
    input  logic                      src2_ready,
    input  ooo_cfg_pkg::rob_tag_t     src2_tag,
    input  ooo_cfg_pkg::data_t        src2_value,
    input  ooo_cfg_pkg::rob_tag_t     dst_tag,
    output logic                      full,
    input  logic                      issue_ready,
    output logic                      issue_valid,
    output ooo_isa_pkg::op_e          issue_op,
    output ooo_cfg_pkg::data_t        issue_a,
    output ooo_cfg_pkg::data_t        issue_b,
    output ooo_cfg_pkg::rob_tag_t     issue_tag,
    input  logic                      cdb_valid,
    input  ooo_cfg_pkg::rob_tag_t     cdb_tag,
    input  ooo_cfg_pkg::data_t        cdb_value
);

    localparam int sel_w = $clog2(depth);

    typedef struct packed {
        logic                  vld;
        ooo_isa_pkg::op_e      op;
        logic                  rdy1;
        logic                  rdy2;
        ooo_cfg_pkg::rob_tag_t tag1;
        ooo_cfg_pkg::rob_tag_t tag2;
        ooo_cfg_pkg::rob_tag_t dst;
        ooo_cfg_pkg::data_t    val1;
        ooo_cfg_pkg::data_t    val2;
    } entry_t;

    // kept compacted, index 0 is the oldest
    entry_t           ent   [depth];
    entry_t           ent_n [depth];
    logic [sel_w-1:0] sel;
    logic             found;
    logic             placed;

    ////////////////////////////////////////////////////////////////////////////
    // select
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        found = 1'b0;
        sel   = '0;
        for (int i = depth - 1; i >= 0; i--) begin  // lowest ready index wins
            if (ent[i].vld && ent[i].rdy1 && ent[i].rdy2) begin
                found = 1'b1;
                sel   = sel_w'(i);
            end
        end
    end

    assign issue_valid = found && issue_ready;
    assign issue_op    = ent[sel].op;
    assign issue_a     = ent[sel].val1;
    assign issue_b     = ent[sel].val2;
    assign issue_tag   = ent[sel].dst;
    assign full        = ent[depth-1].vld;  // compacted, top slot busy means full

    ////////////////////////////////////////////////////////////////////////////
    // wake-up, removal, insert
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        placed = 1'b0;
        for (int i = 0; i < depth; i++) begin
            ent_n[i] = ent[i];
            if (cdb_valid && !ent[i].rdy1 && ent[i].tag1 == cdb_tag) begin
                ent_n[i].rdy1 = 1'b1;
                ent_n[i].val1 = cdb_value;
            end
            if (cdb_valid && !ent[i].rdy2 && ent[i].tag2 == cdb_tag) begin
                ent_n[i].rdy2 = 1'b1;
                ent_n[i].val2 = cdb_value;
            end
        end
        if (issue_valid) begin
            for (int i = 0; i < depth - 1; i++)
                if (i >= int'(sel)) ent_n[i] = ent_n[i + 1];  // close the gap
            ent_n[depth-1].vld = 1'b0;
        end
        for (int i = 0; i < depth; i++) begin
            if (load && !placed && !ent_n[i].vld) begin  // first free slot
                placed   = 1'b1;
                ent_n[i] = '{vld: 1'b1, op: op, rdy1: src1_ready, rdy2: src2_ready,
                             tag1: src1_tag, tag2: src2_tag, dst: dst_tag,
                             val1: src1_value, val2: src2_value};
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) ent[i] <= '0;
        end else begin
            ent <= ent_n;
        end
    end

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  ooo_isa_pkg::op_e          issue_op,
    input  ooo_cfg_pkg::data_t        issue_a,
    input  ooo_cfg_pkg::data_t        issue_b,
    input  ooo_cfg_pkg::rob_tag_t     issue_tag,
    output logic                      issue_ready,
    output logic                      res_valid,
    output ooo_cfg_pkg::rob_tag_t     res_tag,
    output ooo_cfg_pkg::data_t        res_value,
    input  logic                      res_grant
);

    ooo_cfg_pkg::data_t alu_out;

    // result register frees up when empty or leaving this cycle
    assign issue_ready = !res_valid || res_grant;

    always_comb begin
        case (issue_op)
            ooo_isa_pkg::op_add: alu_out = issue_a + issue_b;
            ooo_isa_pkg::op_sub: alu_out = issue_a - issue_b;
            ooo_isa_pkg::op_and: alu_out = issue_a & issue_b;
            ooo_isa_pkg::op_or:  alu_out = issue_a | issue_b;
            ooo_isa_pkg::op_xor: alu_out = issue_a ^ issue_b;
            ooo_isa_pkg::op_sll: alu_out = issue_a << issue_b[4:0];  // shamt low bits
            ooo_isa_pkg::op_slt: alu_out = ooo_cfg_pkg::data_t'($signed(issue_a) <
                                                                $signed(issue_b));
            default:             alu_out = '0;  // mul goes to its own unit
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) res_valid <= 1'b0;
        else if (issue_ready) res_valid <= issue_valid;  // hold while not granted
    end

    always_ff @(posedge clock) begin
        if (issue_valid && issue_ready) begin
            res_tag   <= issue_tag;
            res_value <= alu_out;
        end
    end

endmodule

`default_nettype wire

/* hw/mult_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mult_unit (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  ooo_cfg_pkg::data_t        issue_a,
    input  ooo_cfg_pkg::data_t        issue_b,
    input  ooo_cfg_pkg::rob_tag_t     issue_tag,
    output logic                      res_valid,
    output ooo_cfg_pkg::rob_tag_t     res_tag,
    output ooo_cfg_pkg::data_t        res_value
);

    localparam int last = ooo_cfg_pkg::mult_stages - 1;

    logic [last:0]          vld;               // one bit per stage
    ooo_cfg_pkg::rob_tag_t  tag  [last+1];     // tag rides with the product
    ooo_cfg_pkg::data_t     prod [last+1];

    // never stalls, the arbiter always takes a product
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) vld <= '0;
        else vld <= {vld[last-1:0], issue_valid};
    end

    always_ff @(posedge clock) begin
        tag[0]  <= issue_tag;
        prod[0] <= issue_a * issue_b;          // low xlen bits only
        for (int s = 1; s <= last; s++) begin
            tag[s]  <= tag[s-1];
            prod[s] <= prod[s-1];
        end
    end

    assign res_valid = vld[last];
    assign res_tag   = tag[last];
    assign res_value = prod[last];

endmodule

`default_nettype wire

/* hw/cdb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic                      alu_valid,
    input  ooo_cfg_pkg::rob_tag_t     alu_tag,
    input  ooo_cfg_pkg::data_t        alu_value,
    output logic                      alu_grant,
    input  logic                      mult_valid,
    input  ooo_cfg_pkg::rob_tag_t     mult_tag,
    input  ooo_cfg_pkg::data_t        mult_value,
    output logic                      cdb_valid,
    output ooo_cfg_pkg::rob_tag_t     cdb_tag,
    output ooo_cfg_pkg::data_t        cdb_value
);

    // fixed priority, the multiplier pipe cannot wait
    assign alu_grant = alu_valid && !mult_valid;

    assign cdb_valid = mult_valid || alu_valid;
    assign cdb_tag   = mult_valid ? mult_tag : alu_tag;
    assign cdb_value = mult_valid ? mult_value : alu_value;

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      alloc,
    input  ooo_cfg_pkg::reg_idx_t     alloc_rd,
    output ooo_cfg_pkg::rob_tag_t     alloc_tag,
    output logic                      full,
    input  logic                      cdb_valid,
    input  ooo_cfg_pkg::rob_tag_t     cdb_tag,
    input  ooo_cfg_pkg::data_t        cdb_value,
    input  ooo_cfg_pkg::rob_tag_t     lookup1_tag,
    output logic                      lookup1_ready,
    output ooo_cfg_pkg::data_t        lookup1_value,
    input  ooo_cfg_pkg::rob_tag_t     lookup2_tag,
    output logic                      lookup2_ready,
    output ooo_cfg_pkg::data_t        lookup2_value,
    output logic                      commit_valid,
    output ooo_cfg_pkg::reg_idx_t     commit_idx,
    output ooo_cfg_pkg::data_t        commit_data,
    output ooo_cfg_pkg::rob_tag_t     commit_tag
);

    localparam int cnt_w = $clog2(ooo_cfg_pkg::rob_depth + 1);

    ooo_cfg_pkg::rob_tag_t                head;   // oldest
    ooo_cfg_pkg::rob_tag_t                tail;   // next to hand out
    logic [cnt_w-1:0]                     count;
    logic [ooo_cfg_pkg::rob_depth-1:0]    done;
    ooo_cfg_pkg::reg_idx_t                dst   [ooo_cfg_pkg::rob_depth];
    ooo_cfg_pkg::data_t                   value [ooo_cfg_pkg::rob_depth];

    assign alloc_tag = tail;
    assign full      = count == cnt_w'(ooo_cfg_pkg::rob_depth);

    // operand lookups for dispatch
    assign lookup1_ready = done[lookup1_tag];
    assign lookup1_value = value[lookup1_tag];
    assign lookup2_ready = done[lookup2_tag];
    assign lookup2_value = value[lookup2_tag];

    // head retires as soon as its result is recorded
    assign commit_valid = count != '0 && done[head];
    assign commit_idx   = dst[head];
    assign commit_data  = value[head];
    assign commit_tag   = head;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb_valid) done[cdb_tag] <= 1'b1;
            if (alloc) begin
                done[tail] <= 1'b0;  // never equals a live cdb tag
                tail       <= tail + 1'b1;
            end
            if (commit_valid) head <= head + 1'b1;
            count <= count + cnt_w'(alloc) - cnt_w'(commit_valid);
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) dst[tail] <= alloc_rd;
        if (cdb_valid) value[cdb_tag] <= cdb_value;
    end

endmodule

`default_nettype wire

/* hw/ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
    input  logic                      clock,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  ooo_isa_pkg::op_e          in_op,
    input  ooo_cfg_pkg::reg_idx_t     in_rd,
    input  ooo_cfg_pkg::reg_idx_t     in_rs1,
    input  ooo_cfg_pkg::reg_idx_t     in_rs2,
    input  logic                      in_use_imm,
    input  ooo_cfg_pkg::data_t        in_imm,
    output logic                      in_ready,
    output logic                      commit_valid,
    output ooo_cfg_pkg::reg_idx_t     commit_idx,
    output ooo_cfg_pkg::data_t        commit_data
);

    logic                  rob_alloc, rob_full, rs_alu_full, rs_mult_full;
    ooo_cfg_pkg::rob_tag_t rob_alloc_tag, lookup1_tag, lookup2_tag, commit_tag;
    logic                  lookup1_ready, lookup2_ready, rs_alu_load, rs_mult_load;
    ooo_cfg_pkg::data_t    lookup1_value, lookup2_value, src1_value, src2_value;
    ooo_isa_pkg::op_e      rs_op, alu_iss_op;
    ooo_cfg_pkg::rob_tag_t rs_dst_tag, src1_tag, src2_tag, cdb_tag;
    logic                  src1_ready, src2_ready, cdb_valid;
    ooo_cfg_pkg::data_t    cdb_value;
    logic                  alu_iss_valid, alu_iss_ready, mult_iss_valid;
    ooo_cfg_pkg::data_t    alu_iss_a, alu_iss_b, mult_iss_a, mult_iss_b;
    ooo_cfg_pkg::rob_tag_t alu_iss_tag, mult_iss_tag, alu_res_tag, mult_res_tag;
    logic                  alu_res_valid, alu_grant, mult_res_valid;
    ooo_cfg_pkg::data_t    alu_res_value, mult_res_value;

    ////////////////////////////////////////////////////////////////////////////
    // dispatch, rename and rob
    ////////////////////////////////////////////////////////////////////////////
    dispatch_unit u_dispatch (
        .clock, .rst_n, .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2,
        .in_use_imm, .in_imm, .in_ready, .rob_alloc, .rob_alloc_tag, .rob_full,
        .lookup1_tag, .lookup1_ready, .lookup1_value,
        .lookup2_tag, .lookup2_ready, .lookup2_value,
        .rs_alu_full, .rs_mult_full, .rs_alu_load, .rs_mult_load, .rs_op, .rs_dst_tag,
        .src1_ready, .src1_tag, .src1_value, .src2_ready, .src2_tag, .src2_value,
        .commit_valid, .commit_idx, .commit_data, .commit_tag,
        .cdb_valid, .cdb_tag, .cdb_value
    );

    reorder_buffer u_rob (
        .clock, .rst_n, .alloc(rob_alloc), .alloc_rd(in_rd), .alloc_tag(rob_alloc_tag),
        .full(rob_full), .cdb_valid, .cdb_tag, .cdb_value,
        .lookup1_tag, .lookup1_ready, .lookup1_value,
        .lookup2_tag, .lookup2_ready, .lookup2_value,
        .commit_valid, .commit_idx, .commit_data, .commit_tag
    );

    ////////////////////////////////////////////////////////////////////////////
    // stations and execute
    ////////////////////////////////////////////////////////////////////////////
    reservation_station #(.depth(ooo_cfg_pkg::rs_alu_depth)) u_rs_alu (
        .clock, .rst_n, .load(rs_alu_load), .op(rs_op),
        .src1_ready, .src1_tag, .src1_value, .src2_ready, .src2_tag, .src2_value,
        .dst_tag(rs_dst_tag), .full(rs_alu_full), .issue_ready(alu_iss_ready),
        .issue_valid(alu_iss_valid), .issue_op(alu_iss_op), .issue_a(alu_iss_a),
        .issue_b(alu_iss_b), .issue_tag(alu_iss_tag), .cdb_valid, .cdb_tag, .cdb_value
    );

    reservation_station #(.depth(ooo_cfg_pkg::rs_mult_depth)) u_rs_mult (
        .clock, .rst_n, .load(rs_mult_load), .op(rs_op),
        .src1_ready, .src1_tag, .src1_value, .src2_ready, .src2_tag, .src2_value,
        .dst_tag(rs_dst_tag), .full(rs_mult_full), .issue_ready(1'b1),  // pipe never stalls
        .issue_valid(mult_iss_valid), .issue_op(), .issue_a(mult_iss_a),
        .issue_b(mult_iss_b), .issue_tag(mult_iss_tag), .cdb_valid, .cdb_tag, .cdb_value
    );

    alu_unit u_alu (
        .clock, .rst_n, .issue_valid(alu_iss_valid), .issue_op(alu_iss_op),
        .issue_a(alu_iss_a), .issue_b(alu_iss_b), .issue_tag(alu_iss_tag),
        .issue_ready(alu_iss_ready), .res_valid(alu_res_valid), .res_tag(alu_res_tag),
        .res_value(alu_res_value), .res_grant(alu_grant)
    );

    mult_unit u_mult (
        .clock, .rst_n, .issue_valid(mult_iss_valid), .issue_a(mult_iss_a),
        .issue_b(mult_iss_b), .issue_tag(mult_iss_tag), .res_valid(mult_res_valid),
        .res_tag(mult_res_tag), .res_value(mult_res_value)
    );

    // single result bus
    cdb_arbiter u_cdb (
        .alu_valid(alu_res_valid), .alu_tag(alu_res_tag), .alu_value(alu_res_value),
        .alu_grant, .mult_valid(mult_res_valid), .mult_tag(mult_res_tag),
        .mult_value(mult_res_value), .cdb_valid, .cdb_tag, .cdb_value
    );

endmodule

`default_nettype wire

/* verification/ooo_core_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_asserts (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic                               in_valid,
    input  logic                               in_ready,
    input  logic                               commit_valid,
    input  logic [ooo_cfg_pkg::reg_addr_w-1:0] commit_idx,
    input  logic [ooo_cfg_pkg::xlen-1:0]       commit_data
);

    // rob is empty while held in reset
    a_no_commit_in_reset: assert property (@(posedge clock) !rst_n |-> !commit_valid)
        else $error("commit_valid high during reset");

    // commit payload fully driven
    a_commit_known: assert property (@(posedge clock) disable iff (!rst_n)
        commit_valid |-> !$isunknown({commit_idx, commit_data}))
        else $error("commit_idx or commit_data unknown while commit_valid is high");

    // source keeps offering until taken
    a_valid_held: assert property (@(posedge clock) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid)
        else $error("in_valid dropped before in_ready");

endmodule

bind ooo_core ooo_core_asserts u_asserts (
    .clock, .rst_n, .in_valid, .in_ready, .commit_valid, .commit_idx, .commit_data
);

`default_nettype wire

/* verification/ooo_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

    typedef struct {
        string                              name;
        ooo_isa_pkg::op_e                   op;
        logic [ooo_cfg_pkg::reg_addr_w-1:0] rd;
        logic [ooo_cfg_pkg::reg_addr_w-1:0] rs1;
        logic [ooo_cfg_pkg::reg_addr_w-1:0] rs2;
        logic                               use_imm;
        logic [ooo_cfg_pkg::xlen-1:0]       imm;
        logic [ooo_cfg_pkg::xlen-1:0]       want;      // expected commit data
    } stim_rec_t;

    typedef struct {
        string                              name;
        logic [ooo_cfg_pkg::reg_addr_w-1:0] idx;
        logic [ooo_cfg_pkg::xlen-1:0]       data;
    } commit_rec_t;

    logic                               clock;
    logic                               rst_n;
    logic                               in_valid;
    ooo_isa_pkg::op_e                   in_op;
    logic [ooo_cfg_pkg::reg_addr_w-1:0] in_rd;
    logic [ooo_cfg_pkg::reg_addr_w-1:0] in_rs1;
    logic [ooo_cfg_pkg::reg_addr_w-1:0] in_rs2;
    logic                               in_use_imm;
    logic [ooo_cfg_pkg::xlen-1:0]       in_imm;
    logic                               in_ready;
    logic                               commit_valid;
    logic [ooo_cfg_pkg::reg_addr_w-1:0] commit_idx;
    logic [ooo_cfg_pkg::xlen-1:0]       commit_data;

    stim_rec_t   stim_q [$];
    commit_rec_t exp_q [$];              // dispatch order = commit order
    int          seed          = 89487;
    int          err_cnt       = 0;
    int          burst_stalls  = 0;      // cycles the burst was held off
    int          cycle_cnt     = 0;
    int          timeout_limit = 0;      // 0 until the stim file is in

    ooo_core i_dut (
        .clock, .rst_n, .in_valid, .in_op, .in_rd, .in_rs1, .in_rs2,
        .in_use_imm, .in_imm, .in_ready, .commit_valid, .commit_idx, .commit_data
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;       // 8 ns period
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic fail_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic bit is_burst(input string name);
        return name.len() >= 5 && name.substr(0, 4) == "burst";
    endfunction

    task automatic load_stim();
        int                           fd;
        int                           cnt;
        int                           v_op;
        int                           v_rd;
        int                           v_rs1;
        int                           v_rs2;
        int                           v_imm_en;
        string                        line;
        string                        name;
        logic [ooo_cfg_pkg::xlen-1:0] v_imm;
        logic [ooo_cfg_pkg::xlen-1:0] v_want;
        stim_rec_t                    rec;
        fd = $fopen("verification/ooo_core_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open verification/ooo_core_stim.txt");
            fail_run();
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or comment
                cnt = $sscanf(line, "%s %d %d %d %d %d %h %h", name, v_op, v_rd,
                              v_rs1, v_rs2, v_imm_en, v_imm, v_want);
                if (cnt != 8 || v_op > 7) begin
                    $display("ERROR: malformed stim line: %s", line);
                    fail_run();
                end else begin
                    rec.name    = name;
                    rec.op      = ooo_isa_pkg::op_e'(v_op);
                    rec.rd      = v_rd[ooo_cfg_pkg::reg_addr_w-1:0];
                    rec.rs1     = v_rs1[ooo_cfg_pkg::reg_addr_w-1:0];
                    rec.rs2     = v_rs2[ooo_cfg_pkg::reg_addr_w-1:0];
                    rec.use_imm = v_imm_en != 0;
                    rec.imm     = v_imm;
                    rec.want    = v_want;
                    stim_q.push_back(rec);
                end
            end
            $fclose(fd);
        end
    endtask

    // offer one op and hold it until the handshake edge
    task automatic send_op(input stim_rec_t rec);
        logic        taken;
        commit_rec_t exp;
        in_valid   <= 1'b1;
        in_op      <= rec.op;
        in_rd      <= rec.rd;
        in_rs1     <= rec.rs1;
        in_rs2     <= rec.rs2;
        in_use_imm <= rec.use_imm;
        in_imm     <= rec.imm;
        exp.name = rec.name;
        exp.idx  = rec.rd;
        exp.data = rec.want;
        exp_q.push_back(exp);
        taken = 1'b0;
        while (!taken) begin
            @(negedge clock);                // ready is settled mid-cycle
            taken = in_ready;
            if (!in_ready && is_burst(rec.name)) burst_stalls++;
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        int gap;
        rst_n      <= 1'b0;
        in_valid   <= 1'b0;
        in_op      <= ooo_isa_pkg::op_add;
        in_rd      <= '0;
        in_rs1     <= '0;
        in_rs2     <= '0;
        in_use_imm <= 1'b0;
        in_imm     <= '0;
        load_stim();
        timeout_limit = 20 * stim_q.size() + 100;
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        assert (in_ready === 1'b1) else begin
            $display("MISMATCH test=after_reset in_ready expected 1 actual %b", in_ready);
            fail_run();
        end
        assert (commit_valid === 1'b0) else begin
            $display("MISMATCH test=after_reset commit_valid expected 0 actual %b",
                     commit_valid);
            fail_run();
        end
        @(posedge clock);
        for (int n = 0; n < stim_q.size(); n++) begin
            gap = $unsigned($random(seed)) % 4;
            if (is_burst(stim_q[n].name)) gap = 0;  // burst goes back to back
            if (gap != 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clock);
            end
            send_op(stim_q[n]);
        end
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clock);  // drain the rob
        repeat (10) @(posedge clock);                 // room for a stray commit
        assert (burst_stalls > 0) else begin
            $display("ERROR: in_ready never dropped during the multiply burst");
            err_cnt++;
        end
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // commit checker and timeout
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clock) begin : commit_monitor
        commit_rec_t exp;
        if (rst_n && commit_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("ERROR: commit to r%0d data %h with no operation pending",
                         commit_idx, commit_data);
                fail_run();
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                assert (commit_idx === exp.idx) else begin
                    $display("MISMATCH test=%s commit_idx expected %0d actual %0d",
                             exp.name, exp.idx, commit_idx);
                    fail_run();
                end
                assert (commit_data === exp.data) else begin
                    $display("MISMATCH test=%s commit_data expected %h actual %h",
                             exp.name, exp.data, commit_data);
                    fail_run();
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_cnt++;
        if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
            $display("ERROR: timeout after %0d cycles with %0d commits outstanding",
                     cycle_cnt, exp_q.size());
            fail_run();
        end
    end

endmodule

`default_nettype wire

/* verification/ooo_core_stim.txt */
# name op rd rs1 rs2 use_imm imm expected (op, registers, use_imm decimal; imm, expected hex)
# op codes: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 slt 7 mul
rst_imm    0  1 20  0 1 00000005 00000005
rst_regs   3  2 21 22 0 00000000 00000000
alu_sub    1  3 20  0 1 00000010 fffffff0
alu_and    2  4  1  0 1 0000000c 00000004
alu_xor    4  5  3  0 1 0000ffff ffff000f
alu_sll    5  6  1  0 1 00000004 00000050
alu_slt    6  7  3  0 1 00000001 00000001
chain_add  0  8  6  0 1 00000003 00000053
chain_sub  1  8  8  0 1 00000013 00000040
chain_or   3  9  8  1 0 00000000 00000045
mul_ooo_a  7 11  9  6 0 00000000 00001590
mul_ooo_b  7 12  3  0 1 00000003 ffffffd0
alu_ooo    0 13  1  0 1 00000100 00000105
burst_0    7 15  1  0 1 00000003 0000000f
burst_1    7 15 15  0 1 00000003 0000002d
burst_2    7 15 15  0 1 00000003 00000087
burst_3    7 15 15  0 1 00000003 00000195
burst_4    7 15 15  0 1 00000003 000004bf
burst_5    7 15 15  0 1 00000003 00000e3d
burst_6    7 15 15  0 1 00000003 00002ab7
burst_7    7 15 15  0 1 00000003 00008025
burst_8    7 15 15  0 1 00000003 0001806f
r0_write   0  0  1  0 1 00000007 0000000c
r0_read    0 16  0  0 1 00000009 00000009

/* project.f */
hw/ooo_cfg_pkg.sv
hw/ooo_isa_pkg.sv
hw/dispatch_unit.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/cdb_arbiter.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
verification/ooo_core_asserts.sv
verification/ooo_core_tb.sv

/* Makefile */
# Verilator build and run for the out-of-order core slice

VERILATOR   ?= verilator
TOP         ?= ooo_core_tb
FILELIST    ?= project.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
FAIL_MSG    ?= Simulation FAILED
EXTRA_FLAGS ?=

COMMON_FLAGS = --timing --assert -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) $(EXTRA_FLAGS)

build:
	$(VERILATOR) --binary $(COMMON_FLAGS) -Mdir $(BUILD_DIR) $(EXTRA_FLAGS)

# non-zero exit or the fail line in the log marks a failed run
sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "run reported errors, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
